// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic               clk,
  input  logic               rst,
  mem_bus_if.arbiter         fetch_port,
  mem_bus_if.arbiter         host_port,
  output logic               mem_en,
  output logic               mem_we,
  output fetch_pkg::addr_t   mem_addr,
  output fetch_pkg::data_t   mem_wdata,
  input  fetch_pkg::data_t   mem_rdata
);

  // requests gathered per client index
  logic             in_valid [fetch_pkg::NUM_CLIENTS];
  logic             in_we    [fetch_pkg::NUM_CLIENTS];
  fetch_pkg::addr_t in_addr  [fetch_pkg::NUM_CLIENTS];
  fetch_pkg::data_t in_wdata [fetch_pkg::NUM_CLIENTS];

  // per-client queues, no overflow under the credit rule
  logic             q_we    [fetch_pkg::NUM_CLIENTS][fetch_pkg::CLIENT_CREDITS];
  fetch_pkg::addr_t q_addr  [fetch_pkg::NUM_CLIENTS][fetch_pkg::CLIENT_CREDITS];
  fetch_pkg::data_t q_wdata [fetch_pkg::NUM_CLIENTS][fetch_pkg::CLIENT_CREDITS];
  logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr [fetch_pkg::NUM_CLIENTS];
  logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr [fetch_pkg::NUM_CLIENTS];
  logic [fetch_pkg::QUEUE_CNT_W-1:0] q_count [fetch_pkg::NUM_CLIENTS];

  logic                 grant_any;
  fetch_pkg::client_id_t grant_id;
  fetch_pkg::client_id_t last_id;
  logic                 deq [fetch_pkg::NUM_CLIENTS];
  logic                 credit_q [fetch_pkg::NUM_CLIENTS];

  // owner of each read in the memory pipe
  logic                  pipe_valid [fetch_pkg::MEM_LATENCY];
  fetch_pkg::client_id_t pipe_id    [fetch_pkg::MEM_LATENCY];

  function automatic logic [fetch_pkg::QUEUE_PTR_W-1:0] ptr_inc(
    input logic [fetch_pkg::QUEUE_PTR_W-1:0] ptr
  );
    if (int'(ptr) == fetch_pkg::CLIENT_CREDITS - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_valid[fetch_pkg::CLIENT_FETCH] = fetch_port.req_valid;
  assign in_we[fetch_pkg::CLIENT_FETCH]    = fetch_port.req_we;
  assign in_addr[fetch_pkg::CLIENT_FETCH]  = fetch_port.req_addr;
  assign in_wdata[fetch_pkg::CLIENT_FETCH] = fetch_port.req_wdata;
  assign in_valid[fetch_pkg::CLIENT_HOST]  = host_port.req_valid;
  assign in_we[fetch_pkg::CLIENT_HOST]     = host_port.req_we;
  assign in_addr[fetch_pkg::CLIENT_HOST]   = host_port.req_addr;
  assign in_wdata[fetch_pkg::CLIENT_HOST]  = host_port.req_wdata;

  // round robin, start searching after the last winner
  always_comb begin
    fetch_pkg::client_id_t cand;
    grant_any = 1'b0;
    grant_id = last_id;
    for (int i = 1; i <= fetch_pkg::NUM_CLIENTS; i++) begin
      cand = fetch_pkg::client_id_t'((int'(last_id) + i) % fetch_pkg::NUM_CLIENTS);
      if (!grant_any && q_count[cand] != '0) begin
        grant_any = 1'b1;
        grant_id = cand;
      end
    end
    for (int c = 0; c < fetch_pkg::NUM_CLIENTS; c++) begin
      deq[c] = grant_any && (int'(grant_id) == c);
    end
  end

  // queue head straight to memory
  assign mem_en    = grant_any;
  assign mem_we    = q_we[grant_id][rd_ptr[grant_id]];
  assign mem_addr  = q_addr[grant_id][rd_ptr[grant_id]];
  assign mem_wdata = q_wdata[grant_id][rd_ptr[grant_id]];

  // queue storage
  always_ff @(posedge clk) begin
    for (int c = 0; c < fetch_pkg::NUM_CLIENTS; c++) begin
      if (in_valid[c]) begin
        q_we[c][wr_ptr[c]]    <= in_we[c];
        q_addr[c][wr_ptr[c]]  <= in_addr[c];
        q_wdata[c][wr_ptr[c]] <= in_wdata[c];
      end
    end
  end

  // queue control, credit return and read tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      last_id <= fetch_pkg::CLIENT_HOST;
      for (int c = 0; c < fetch_pkg::NUM_CLIENTS; c++) begin
        wr_ptr[c] <= '0;
        rd_ptr[c] <= '0;
        q_count[c] <= '0;
        credit_q[c] <= 1'b0;
      end
      for (int s = 0; s < fetch_pkg::MEM_LATENCY; s++) begin
        pipe_valid[s] <= 1'b0;
      end
    end else begin
      if (grant_any) begin
        last_id <= grant_id;
      end
      for (int c = 0; c < fetch_pkg::NUM_CLIENTS; c++) begin
        if (in_valid[c]) begin
          wr_ptr[c] <= ptr_inc(wr_ptr[c]);
        end
        if (deq[c]) begin
          rd_ptr[c] <= ptr_inc(rd_ptr[c]);
        end
        q_count[c] <= q_count[c] + {{(fetch_pkg::QUEUE_CNT_W-1){1'b0}}, in_valid[c]}
                      - {{(fetch_pkg::QUEUE_CNT_W-1){1'b0}}, deq[c]};
        // credit back one cycle after dequeue
        credit_q[c] <= deq[c];
      end
      // only reads enter the owner shift
      pipe_valid[0] <= grant_any && !mem_we;
      for (int s = 1; s < fetch_pkg::MEM_LATENCY; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_id[0] <= grant_id;
    for (int s = 1; s < fetch_pkg::MEM_LATENCY; s++) begin
      pipe_id[s] <= pipe_id[s-1];
    end
  end

  assign fetch_port.credit_ret = credit_q[fetch_pkg::CLIENT_FETCH];
  assign host_port.credit_ret  = credit_q[fetch_pkg::CLIENT_HOST];

  // read data lands MEM_LATENCY cycles after grant
  assign fetch_port.rsp_valid = pipe_valid[fetch_pkg::MEM_LATENCY-1]
                                && (pipe_id[fetch_pkg::MEM_LATENCY-1] == fetch_pkg::CLIENT_FETCH);
  assign host_port.rsp_valid  = pipe_valid[fetch_pkg::MEM_LATENCY-1]
                                && (pipe_id[fetch_pkg::MEM_LATENCY-1] == fetch_pkg::CLIENT_HOST);
  assign fetch_port.rsp_data  = mem_rdata;
  assign host_port.rsp_data   = mem_rdata;

endmodule

// File: rtl/fetch_pkg.sv
package fetch_pkg;

  // basic widths
  localparam int ADDR_W = 10;
  localparam int DATA_W = 32;
  localparam int CREDIT_W = 3;
  localparam int OPCODE_W = 8;

  // word address into shared memory
  typedef logic [ADDR_W-1:0] addr_t;
  // data word or command word
  typedef logic [DATA_W-1:0] data_t;
  // credit counter
  typedef logic [CREDIT_W-1:0] credit_t;
  // arbiter client index
  typedef logic [0:0] client_id_t;

  localparam int MEM_DEPTH = 1024;
  localparam int NUM_CLIENTS = 2;

  // arbiter client slots
  localparam client_id_t CLIENT_FETCH = 1'b0;
  localparam client_id_t CLIENT_HOST = 1'b1;

  // request credits per client, same as arbiter queue depth
  localparam int CLIENT_CREDITS = 2;
  localparam int QUEUE_PTR_W = $clog2(CLIENT_CREDITS);
  localparam int QUEUE_CNT_W = $clog2(CLIENT_CREDITS + 1);

  // command credits toward the executor
  localparam int CMD_CREDITS = 4;

  // instruction pointer register, relative to base_addr
  localparam addr_t REG_IP_OFFSET = addr_t'(4);

  // top byte of a halt command
  localparam logic [OPCODE_W-1:0] HALT_OPCODE = 8'hFF;

  // grant to response, in cycles
  localparam int MEM_LATENCY = 2;

  typedef enum logic [2:0] {
    st_idle,
    st_read_ip,
    st_wait_ip,
    st_read_cmd,
    st_wait_cmd,
    st_write_ip,
    st_emit
  } fetch_state_t;

endpackage

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  fetch_pkg::addr_t   base_addr,
  output logic               busy,
  output logic               cmd_valid,
  output fetch_pkg::data_t   cmd_data,
  input  logic               cmd_credit,
  input  logic               host_valid,
  input  logic               host_we,
  input  fetch_pkg::addr_t   host_addr,
  input  fetch_pkg::data_t   host_wdata,
  output logic               host_credit,
  output logic               host_rvalid,
  output fetch_pkg::data_t   host_rdata
);

  // arbiter to memory
  logic             mem_en;
  logic             mem_we;
  fetch_pkg::addr_t mem_addr;
  fetch_pkg::data_t mem_wdata;
  fetch_pkg::data_t mem_rdata;

  // one bus per arbiter client
  mem_bus_if fetch_bus ();
  mem_bus_if host_bus ();

  // host plain ports onto its bus
  assign host_bus.req_valid = host_valid;
  assign host_bus.req_we    = host_we;
  assign host_bus.req_addr  = host_addr;
  assign host_bus.req_wdata = host_wdata;
  assign host_credit        = host_bus.credit_ret;
  assign host_rvalid        = host_bus.rsp_valid;
  assign host_rdata         = host_bus.rsp_data;

  start_manager start_manager_inst (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .base_addr  (base_addr),
    .busy       (busy),
    .bus        (fetch_bus.client),
    .cmd_valid  (cmd_valid),
    .cmd_data   (cmd_data),
    .cmd_credit (cmd_credit)
  );

  bus_arbiter bus_arbiter_inst (
    .clk        (clk),
    .rst        (rst),
    .fetch_port (fetch_bus.arbiter),
    .host_port  (host_bus.arbiter),
    .mem_en     (mem_en),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata)
  );

  // memory has no reset
  shared_memory shared_memory_inst (
    .clk        (clk),
    .mem_en     (mem_en),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata)
  );

endmodule

// File: rtl/mem_bus_if.sv
`timescale 1ns/1ps

// one client's path into the arbiter
interface mem_bus_if;

  // request channel, one beat per credit
  logic req_valid;
  logic req_we;
  fetch_pkg::addr_t req_addr;
  fetch_pkg::data_t req_wdata;

  // one pulse gives one credit back
  logic credit_ret;

  // read data, in request order
  logic rsp_valid;
  fetch_pkg::data_t rsp_data;

  modport client (
    output req_valid,
    output req_we,
    output req_addr,
    output req_wdata,
    input  credit_ret,
    input  rsp_valid,
    input  rsp_data
  );

  modport arbiter (
    input  req_valid,
    input  req_we,
    input  req_addr,
    input  req_wdata,
    output credit_ret,
    output rsp_valid,
    output rsp_data
  );

endinterface

// File: rtl/shared_memory.sv
`timescale 1ns/1ps

module shared_memory (
  input  logic               clk,
  input  logic               mem_en,
  input  logic               mem_we,
  input  fetch_pkg::addr_t   mem_addr,
  input  fetch_pkg::data_t   mem_wdata,
  output fetch_pkg::data_t   mem_rdata
);

  // word array, contents undefined at start
  fetch_pkg::data_t mem [fetch_pkg::MEM_DEPTH];

  // first read stage, array output register
  fetch_pkg::data_t rd_stage;

  // single port, write or read per access
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        rd_stage <= mem[mem_addr];
      end
    end
  end

  // second read stage
  // free running, the arbiter knows which beats are real
  always_ff @(posedge clk) begin
    mem_rdata <= rd_stage;
  end

endmodule

// File: rtl/start_manager.sv
`timescale 1ns/1ps

module start_manager (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  fetch_pkg::addr_t   base_addr,
  output logic               busy,
  mem_bus_if.client          bus,
  output logic               cmd_valid,
  output fetch_pkg::data_t   cmd_data,
  input  logic               cmd_credit
);

  fetch_pkg::fetch_state_t state;

  // address of the ip register, latched on run
  fetch_pkg::addr_t ip_addr;
  // pointer read from the ip register
  fetch_pkg::addr_t cmd_ptr;
  fetch_pkg::addr_t next_ptr;
  // fetched command, held until emitted
  fetch_pkg::data_t cmd_q;

  fetch_pkg::credit_t bus_credits;
  fetch_pkg::credit_t cmd_credits;

  logic has_bus_credit;
  logic is_halt;

  assign has_bus_credit = (bus_credits != '0);
  assign next_ptr = cmd_ptr + fetch_pkg::addr_t'(1);
  // halt is any command with the halt opcode on top
  assign is_halt = (cmd_q[fetch_pkg::DATA_W-1 -: fetch_pkg::OPCODE_W] == fetch_pkg::HALT_OPCODE);

  assign busy = (state != fetch_pkg::st_idle);

  // emit only while the executor has room
  assign cmd_valid = (state == fetch_pkg::st_emit) && (cmd_credits != '0);
  assign cmd_data = cmd_q;

  // request drive, one beat per request state
  always_comb begin
    bus.req_valid = 1'b0;
    bus.req_we = 1'b0;
    bus.req_addr = ip_addr;
    bus.req_wdata = '0;
    case (state)
      fetch_pkg::st_read_ip: begin
        bus.req_valid = has_bus_credit;
      end
      fetch_pkg::st_read_cmd: begin
        bus.req_valid = has_bus_credit;
        bus.req_addr = cmd_ptr;
      end
      fetch_pkg::st_write_ip: begin
        // pointer goes back zero extended
        bus.req_valid = has_bus_credit;
        bus.req_we = 1'b1;
        bus.req_wdata = {{(fetch_pkg::DATA_W - fetch_pkg::ADDR_W){1'b0}}, next_ptr};
      end
      default: begin
        bus.req_valid = 1'b0;
      end
    endcase
  end

  // credit bookkeeping, spend and return may coincide
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_credits <= fetch_pkg::credit_t'(fetch_pkg::CLIENT_CREDITS);
      cmd_credits <= fetch_pkg::credit_t'(fetch_pkg::CMD_CREDITS);
    end else begin
      bus_credits <= bus_credits + fetch_pkg::credit_t'(bus.credit_ret)
                     - fetch_pkg::credit_t'(bus.req_valid);
      cmd_credits <= cmd_credits + fetch_pkg::credit_t'(cmd_credit)
                     - fetch_pkg::credit_t'(cmd_valid);
    end
  end

  // fetch FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_pkg::st_idle;
    end else begin
      case (state)
        fetch_pkg::st_idle: begin
          // run only seen here, so ignored while busy
          if (run) begin
            state <= fetch_pkg::st_read_ip;
          end
        end
        fetch_pkg::st_read_ip: begin
          if (has_bus_credit) begin
            state <= fetch_pkg::st_wait_ip;
          end
        end
        fetch_pkg::st_wait_ip: begin
          if (bus.rsp_valid) begin
            state <= fetch_pkg::st_read_cmd;
          end
        end
        fetch_pkg::st_read_cmd: begin
          if (has_bus_credit) begin
            state <= fetch_pkg::st_wait_cmd;
          end
        end
        fetch_pkg::st_wait_cmd: begin
          if (bus.rsp_valid) begin
            state <= fetch_pkg::st_write_ip;
          end
        end
        fetch_pkg::st_write_ip: begin
          if (has_bus_credit) begin
            state <= fetch_pkg::st_emit;
          end
        end
        fetch_pkg::st_emit: begin
          if (cmd_valid) begin
            state <= is_halt ? fetch_pkg::st_idle : fetch_pkg::st_read_ip;
          end
        end
        default: begin
          state <= fetch_pkg::st_idle;
        end
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (state == fetch_pkg::st_idle && run) begin
      ip_addr <= base_addr + fetch_pkg::REG_IP_OFFSET;
    end
    if (state == fetch_pkg::st_wait_ip && bus.rsp_valid) begin
      cmd_ptr <= bus.rsp_data[fetch_pkg::ADDR_W-1:0];
    end
    if (state == fetch_pkg::st_wait_cmd && bus.rsp_valid) begin
      cmd_q <= bus.rsp_data;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module fetch_tb -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: tb/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int MAX_PROG = 20;
  localparam int CONT_OPS = 30;
  // 200 cycles per program word and per host access, both runs
  localparam int WATCHDOG_CYCLES = 200 * 2 * (3 * MAX_PROG + 3 + CONT_OPS) + 100;

  logic clk;
  logic rst;
  logic run;
  fetch_pkg::addr_t base_addr;
  logic busy;
  logic cmd_valid;
  fetch_pkg::data_t cmd_data;
  logic cmd_credit;
  logic host_valid;
  logic host_we;
  fetch_pkg::addr_t host_addr;
  fetch_pkg::data_t host_wdata;
  logic host_credit;
  logic host_rvalid;
  fetch_pkg::data_t host_rdata;

  integer seed;
  // mirror of the shared memory
  fetch_pkg::data_t model [fetch_pkg::MEM_DEPTH];
  // expected host read data and commands, in order
  fetch_pkg::data_t rd_exp [$];
  fetch_pkg::data_t cmd_exp [$];
  fetch_pkg::addr_t written [$];
  int reqs_sent;
  int credits_back;
  int rd_seen;
  int cmd_seen;
  int cmd_freed;
  int hold_cycles;
  logic halt_seen;
  fetch_pkg::data_t want;

  fetch_top fetch_top_inst (
    .clk(clk), .rst(rst), .run(run), .base_addr(base_addr), .busy(busy),
    .cmd_valid(cmd_valid), .cmd_data(cmd_data), .cmd_credit(cmd_credit),
    .host_valid(host_valid), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_credit(host_credit), .host_rvalid(host_rvalid),
    .host_rdata(host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_eq(input fetch_pkg::data_t got, input fetch_pkg::data_t exp_val,
                          input string what);
    if (got !== exp_val) begin
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp_val);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  function automatic int rand_below(input int m);
    return int'($unsigned($random(seed)) % m);
  endfunction

  // one host request, only while a credit is left
  task automatic host_access(input logic we, input fetch_pkg::addr_t addr,
                             input fetch_pkg::data_t wdata);
    while (fetch_pkg::CLIENT_CREDITS + credits_back - reqs_sent == 0) begin
      @(posedge clk);
      #1;
    end
    host_valid = 1'b1;
    host_we = we;
    host_addr = addr;
    host_wdata = wdata;
    reqs_sent++;
    if (we) begin
      model[addr] = wdata;
    end else begin
      rd_exp.push_back(model[addr]);
    end
    @(posedge clk);
    #1;
    host_valid = 1'b0;
    host_we = 1'b0;
  endtask

  // all reads answered and all credits home
  task automatic drain_host();
    while (rd_seen != rd_exp.size() || credits_back != reqs_sent) begin
      @(posedge clk);
      #1;
    end
  endtask

  // program with a halt at the end, then the pointer, then readback
  task automatic load_program(input fetch_pkg::addr_t base, input fetch_pkg::addr_t ptr,
                              input int n);
    fetch_pkg::addr_t reg_addr;
    logic [7:0] op;
    fetch_pkg::data_t w;
    reg_addr = base + fetch_pkg::REG_IP_OFFSET;
    for (int i = 0; i < n; i++) begin
      op = 8'($random(seed));
      if (op == fetch_pkg::HALT_OPCODE || i == n - 1) begin
        op = (i == n - 1) ? fetch_pkg::HALT_OPCODE : 8'h00;
      end
      w = {op, 24'($random(seed))};
      host_access(1'b1, fetch_pkg::addr_t'(ptr + i), w);
      cmd_exp.push_back(w);
    end
    host_access(1'b1, reg_addr, fetch_pkg::data_t'(ptr));
    for (int i = 0; i < n; i++) begin
      host_access(1'b0, fetch_pkg::addr_t'(ptr + i), '0);
    end
    host_access(1'b0, reg_addr, '0);
    drain_host();
  endtask

  // random host traffic well away from program and register
  task automatic contend(input int ops);
    fetch_pkg::addr_t a;
    for (int i = 0; i < ops; i++) begin
      if (written.size() == 0 || rand_below(2) == 0) begin
        a = 10'h300 | fetch_pkg::addr_t'(rand_below(256));
        host_access(1'b1, a, fetch_pkg::data_t'($random(seed)));
        written.push_back(a);
      end else begin
        host_access(1'b0, written[rand_below(written.size())], '0);
      end
    end
  endtask

  task automatic fetch_run(input fetch_pkg::addr_t base, input fetch_pkg::addr_t ptr,
                           input int n, input logic stray, input fetch_pkg::addr_t stray_base);
    fetch_pkg::addr_t reg_addr;
    reg_addr = base + fetch_pkg::REG_IP_OFFSET;
    base_addr = base;
    run = 1'b1;
    @(posedge clk);
    #1;
    run = 1'b0;
    fork
      contend(CONT_OPS);
      begin
        if (stray) begin
          // second pulse mid-run, pointing elsewhere
          repeat (3) @(posedge clk);
          #1;
          check_eq(fetch_pkg::data_t'(busy), 32'd1, "busy during run");
          base_addr = stray_base;
          run = 1'b1;
          @(posedge clk);
          #1;
          run = 1'b0;
          base_addr = base;
        end
        while (busy) begin
          @(posedge clk);
          #1;
        end
      end
    join
    drain_host();
    check_eq(fetch_pkg::data_t'(cmd_seen), fetch_pkg::data_t'(cmd_exp.size()),
             "commands fetched");
    // fetch wrote back start pointer plus command count
    model[reg_addr] = fetch_pkg::data_t'(ptr) + fetch_pkg::data_t'(n);
    host_access(1'b0, reg_addr, '0);
    drain_host();
  endtask

  // responses sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (halt_seen) begin
        check_eq(fetch_pkg::data_t'(busy), '0, "busy after halt");
        halt_seen = 1'b0;
      end
      if (host_credit) begin
        credits_back++;
        check_eq(fetch_pkg::data_t'(credits_back <= reqs_sent), 32'd1, "extra host credit");
      end
      if (host_rvalid) begin
        check_eq(fetch_pkg::data_t'(rd_seen < rd_exp.size()), 32'd1, "unrequested read");
        check_eq(host_rdata, rd_exp[rd_seen], "host read data");
        rd_seen++;
      end
      if (cmd_valid) begin
        check_eq(fetch_pkg::data_t'(cmd_seen < cmd_exp.size()), 32'd1, "unexpected command");
        want = cmd_exp[cmd_seen];
        check_eq(cmd_data, want, "command data");
        cmd_seen++;
        check_eq(fetch_pkg::data_t'(cmd_seen - cmd_freed <= fetch_pkg::CMD_CREDITS), 32'd1,
                 "commands beyond credit");
        halt_seen = (want[31:24] == fetch_pkg::HALT_OPCODE);
      end
    end
  end

  // consumer, returns credits with random stalls
  initial begin
    cmd_credit = 1'b0;
    hold_cycles = 0;
    forever begin
      @(posedge clk);
      #1;
      cmd_credit = 1'b0;
      if (hold_cycles > 0) begin
        hold_cycles--;
      end else if (cmd_seen > cmd_freed && rand_below(4) != 0) begin
        cmd_credit = 1'b1;
        cmd_freed++;
      end else if (rand_below(16) == 0) begin
        hold_cycles = 10 + rand_below(32);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  initial begin
    fetch_pkg::addr_t base1;
    fetch_pkg::addr_t ptr1;
    fetch_pkg::addr_t base2;
    fetch_pkg::addr_t ptr2;
    int n1;
    int n2;
    seed = 32'h4db4_ce8d;
    rst = 1'b1;
    run = 1'b0;
    base_addr = '0;
    host_valid = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    reqs_sent = 0;
    credits_back = 0;
    rd_seen = 0;
    cmd_seen = 0;
    cmd_freed = 0;
    halt_seen = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_eq(fetch_pkg::data_t'({busy, cmd_valid, host_credit, host_rvalid}), '0,
             "outputs after reset");
    // first program low in memory
    base1 = fetch_pkg::addr_t'(rand_below(128));
    ptr1 = base1 + fetch_pkg::addr_t'(16 + rand_below(16));
    n1 = 8 + rand_below(MAX_PROG - 7);
    load_program(base1, ptr1, n1);
    fetch_run(base1, ptr1, n1, 1'b0, base1);
    // second program in its own window
    base2 = 10'h100 | fetch_pkg::addr_t'(rand_below(128));
    ptr2 = base2 + fetch_pkg::addr_t'(16 + rand_below(16));
    n2 = 8 + rand_below(MAX_PROG - 7);
    load_program(base2, ptr2, n2);
    fetch_run(base2, ptr2, n2, 1'b1, base1);
    // stray pulse must not have started a third run
    repeat (20) @(posedge clk);
    #1;
    check_eq(fetch_pkg::data_t'(busy), '0, "busy after second run");
    check_eq(fetch_pkg::data_t'(cmd_seen), fetch_pkg::data_t'(cmd_exp.size()), "late commands");
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: vlog.f
rtl/fetch_pkg.sv
rtl/mem_bus_if.sv
rtl/shared_memory.sv
rtl/bus_arbiter.sv
rtl/start_manager.sv
rtl/fetch_top.sv
tb/fetch_tb.sv
